/* verilog.f */
common/isa_pkg.sv
common/core_pkg.sv
backend/reg_file.sv
backend/backend.sv
frontend/frontend.sv
rtl/main_cu.sv
rtl/datapath.sv
tests/tb_datapath.sv

/* Makefile */
TOP := tb_datapath

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tests/tb_datapath.sv */
// Random memory latency and ready, fixed LCG seed, one program ending in an illegal opcode
// Memory words outside the program read back as their own address, which is an illegal opcode
`timescale 1ns/1ns
`default_nettype none

module tb_datapath;

    localparam logic [31:0] BOOT_PC      = 32'h0000_0100;
    localparam int          PROG_LEN     = 32;
    localparam int          MAX_RET      = 128;
    localparam int          HALT_TIMEOUT = 2000;

    logic                   clk;
    logic                   reset;
    logic                   imem_req_rdy;
    core_pkg::imem_ans_t    imem_ans;
    core_pkg::imem_req_t    imem_req;
    core_pkg::retire_t      retire;
    core_pkg::except_t      except_info;
    logic                   halted;

    logic [31:0]    prog [PROG_LEN];
    logic [31:0]    exp_pc [MAX_RET];
    logic [4:0]     exp_rd [MAX_RET];
    logic [31:0]    exp_val [MAX_RET];
    int             exp_n;
    logic [31:0]    exp_exc_pc;
    logic           exc_found;
    int             ret_idx;
    int             errors = 0;
    logic [31:0]    rng_state = 32'hf7db2ddf;

    logic           req_taken = 1'b0;
    logic [31:0]    req_addr;
    logic [31:0]    prev_req_addr;
    logic [31:0]    pend_addr [$];
    int             pend_wait [$];

    datapath #(
        .BOOT_PC            (BOOT_PC),
        .MAX_OUTSTANDING    (2)
    ) UUT (
        .clk_i          (clk),
        .reset_i        (reset),
        .imem_req_rdy_i (imem_req_rdy),
        .imem_ans_i     (imem_ans),
        .imem_req_o     (imem_req),
        .retire_o       (retire),
        .except_o       (except_info),
        .halted_o       (halted)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, isa_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input int imm);
        logic [11:0] i12;
        i12 = imm[11:0];
        return {i12, rs1, 3'b000, rd, isa_pkg::OPC_OPIMM};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, isa_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - BOOT_PC) >> 2;
        if (addr >= BOOT_PC && idx < PROG_LEN) begin
            return prog[idx[4:0]];
        end
        return addr;
    endfunction

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = BOOT_PC + 32'(4 * i);
        end
        prog[0]  = lui_word(5'd1, 20'h12345);
        prog[1]  = addi_word(5'd2, 5'd0, 5);
        prog[2]  = addi_word(5'd3, 5'd2, -3);
        prog[3]  = rtype_word(7'h00, 5'd4, 5'd1, 5'd2);
        prog[4]  = rtype_word(7'h20, 5'd5, 5'd3, 5'd2);
        prog[5]  = addi_word(5'd0, 5'd2, 7);
        prog[6]  = rtype_word(7'h00, 5'd6, 5'd0, 5'd0);
        prog[7]  = branch_word(3'b000, 5'd2, 5'd3, 8);     // not taken
        prog[8]  = branch_word(3'b001, 5'd2, 5'd3, 12);
        prog[9]  = addi_word(5'd7, 5'd0, 1);
        prog[10] = addi_word(5'd7, 5'd0, 2);
        prog[11] = jal_word(5'd8, 12);
        prog[12] = addi_word(5'd9, 5'd0, 3);
        prog[13] = addi_word(5'd9, 5'd0, 4);
        prog[14] = branch_word(3'b000, 5'd6, 5'd0, 8);
        prog[15] = addi_word(5'd9, 5'd0, 5);
        prog[16] = rtype_word(7'h20, 5'd10, 5'd5, 5'd4);
        prog[17] = jal_word(5'd0, 8);
        prog[18] = addi_word(5'd9, 5'd0, 6);
        prog[19] = addi_word(5'd11, 5'd10, 100);
        prog[20] = addi_word(5'd13, 5'd0, 4);
        // Backward loop, four passes
        prog[21] = addi_word(5'd13, 5'd13, -1);
        prog[22] = branch_word(3'b001, 5'd13, 5'd0, -4);
        // MUL encoding, outside the subset
        prog[23] = rtype_word(7'h01, 5'd12, 5'd1, 5'd2);
        prog[24] = addi_word(5'd12, 5'd0, 1);
    endtask

    // ------------------------------
    // ISA reference model
    // ------------------------------
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic        wr;
        logic        legal;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = BOOT_PC;
        exp_n = 0;
        exc_found = 1'b0;
        while (!exc_found && exp_n < MAX_RET) begin
            ins = mem_word(pc);
            rs1v = regs[ins[19:15]];
            rs2v = regs[ins[24:20]];
            next_pc = pc + 32'd4;
            val = '0;
            wr = 1'b0;
            legal = 1'b1;
            case (ins[6:0])
                isa_pkg::OPC_LUI: begin
                    val = {ins[31:12], 12'b0};
                    wr = 1'b1;
                end
                isa_pkg::OPC_OPIMM: begin
                    val = rs1v + {{20{ins[31]}}, ins[31:20]};
                    wr = 1'b1;
                    legal = (ins[14:12] == 3'b000);
                end
                isa_pkg::OPC_OP: begin
                    val = (ins[31:25] == 7'h20) ? rs1v - rs2v : rs1v + rs2v;
                    wr = 1'b1;
                    legal = (ins[14:12] == 3'b000) && (ins[31:25] == 7'h00 || ins[31:25] == 7'h20);
                end
                isa_pkg::OPC_BRANCH: begin
                    legal = (ins[14:12] == 3'b000 || ins[14:12] == 3'b001);
                    if ((ins[14:12] == 3'b000) ? (rs1v == rs2v) : (rs1v != rs2v)) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                isa_pkg::OPC_JAL: begin
                    val = pc + 32'd4;
                    wr = 1'b1;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: legal = 1'b0;
            endcase
            if (!legal) begin
                exc_found = 1'b1;
                exp_exc_pc = pc;
            end else begin
                exp_pc[exp_n] = pc;
                exp_rd[exp_n] = wr ? ins[11:7] : 5'd0;
                exp_val[exp_n] = (wr && ins[11:7] != 5'd0) ? val : 32'd0;
                if (wr && ins[11:7] != 5'd0) begin
                    regs[ins[11:7]] = val;
                end
                exp_n++;
                pc = next_pc;
            end
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    // Request outputs settle well before the falling edge
    always @(negedge clk) begin
        req_taken = !reset && imem_req.valid && imem_req_rdy;
        prev_req_addr = req_addr;
        req_addr = imem_req.addr;
    end

    always @(posedge clk) begin
        logic [31:0] rnd;
        #1;
        if (req_taken) begin
            rnd = next_rand();
            pend_addr.push_back(req_addr);
            pend_wait.push_back(int'(rnd[31:30]));
        end
        imem_ans = '0;
        if (pend_addr.size() != 0) begin
            if (pend_wait[0] == 0) begin
                imem_ans.valid = 1'b1;
                imem_ans.data = mem_word(pend_addr.pop_front());
                void'(pend_wait.pop_front());
            end else begin
                pend_wait[0] = pend_wait[0] - 1;
            end
        end
        rnd = next_rand();
        imem_req_rdy = (rnd[31:30] != 2'b00);
    end

    always @(posedge clk) begin
        if (reset) begin
            ret_idx <= 0;
        end else if (retire.valid) begin
            ret_idx <= ret_idx + 1;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_retire_count: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> ret_idx < exp_n)
        else begin
            errors++;
            $display("Retire seen after all %0d expected instructions", exp_n);
        end

    a_retire_pc: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.pc == exp_pc[ret_idx])
        else begin
            errors++;
            $display("MISMATCH retire_o.pc: got %h expected %h",
                     $sampled(retire.pc), exp_pc[$sampled(ret_idx)]);
        end

    a_retire_rd: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.rd == exp_rd[ret_idx])
        else begin
            errors++;
            $display("MISMATCH retire_o.rd: got %h expected %h",
                     $sampled(retire.rd), exp_rd[$sampled(ret_idx)]);
        end

    a_retire_value: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.value == exp_val[ret_idx])
        else begin
            errors++;
            $display("MISMATCH retire_o.value: got %h expected %h",
                     $sampled(retire.value), exp_val[$sampled(ret_idx)]);
        end

    // Memory sees no request while the core is in reset
    a_req_reset: assert property (@(posedge clk)
        reset |-> !imem_req.valid)
        else begin
            errors++;
            $display("Fetch request raised during reset");
        end

    // A request waiting for ready stays up unless a flush drops it
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        imem_req.valid && !imem_req_rdy |=> imem_req.valid || UUT.cu_flush)
        else begin
            errors++;
            $display("Fetch request withdrawn while memory was not ready");
        end

    a_req_addr_hold: assert property (@(posedge clk) disable iff (reset)
        imem_req.valid && !imem_req_rdy |=>
            !imem_req.valid || imem_req.addr == prev_req_addr)
        else begin
            errors++;
            $display("MISMATCH imem_req_o.addr: got %h expected %h",
                     $sampled(imem_req.addr), $sampled(prev_req_addr));
        end

    // Halt follows the accepted illegal instruction by one cycle
    a_halt_timing: assert property (@(posedge clk) disable iff (reset)
        UUT.be_except.valid |=> halted && except_info.valid)
        else begin
            errors++;
            $display("Halt did not follow the illegal instruction by one cycle");
        end

    a_halt_pair: assert property (@(posedge clk) disable iff (reset)
        halted == except_info.valid)
        else begin
            errors++;
            $display("halted_o and except_o.valid disagree");
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            errors++;
            $display("halted_o dropped before reset");
        end

    a_except_pc: assert property (@(posedge clk) disable iff (reset)
        except_info.valid |-> except_info.pc == exp_exc_pc)
        else begin
            errors++;
            $display("MISMATCH except_o.pc: got %h expected %h",
                     $sampled(except_info.pc), exp_exc_pc);
        end

    a_quiet_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire.valid)
        else begin
            errors++;
            $display("Instruction retired while halted");
        end

    initial begin
        int cycles;
        clk = 1'b0;
        reset = 1'b1;
        imem_req_rdy = 1'b0;
        imem_ans = '0;
        load_program();
        run_model();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("Timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
        end else begin
            // Watch for stray retires after the halt
            repeat (20) @(negedge clk);
        end

        if (!exc_found) begin
            errors++;
            $display("Reference model found no illegal instruction");
        end
        if (ret_idx != exp_n) begin
            errors++;
            $display("Retired %0d instructions, model expects %0d", ret_idx, exp_n);
        end
        $display("Errors: %0d, retired %0d of %0d", errors, ret_idx, exp_n);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/datapath.sv */
// Top level, instruction memory is external and may stall or delay answers
`timescale 1ns/1ns
`default_nettype none

module datapath #(
    parameter logic [isa_pkg::XLEN-1:0] BOOT_PC         = '0,
    parameter int unsigned              MAX_OUTSTANDING = 2
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    imem_req_rdy_i,
    input  core_pkg::imem_ans_t     imem_ans_i,
    output core_pkg::imem_req_t     imem_req_o,
    output core_pkg::retire_t       retire_o,
    output core_pkg::except_t       except_o,
    output logic                    halted_o
);

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic                   fe_be_valid;
    core_pkg::fetch_t       fe_be_fetch;
    logic                   be_fe_ready;
    core_pkg::resolution_t  be_res;
    core_pkg::except_t      be_except;
    logic                   cu_flush;
    logic                   cu_stall;

    main_cu u_main_cu (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .res_i          (be_res),
        .except_i       (be_except),
        .flush_o        (cu_flush),
        .stall_o        (cu_stall),
        .halted_o       (halted_o),
        .except_o       (except_o)
    );

    frontend #(
        .BOOT_PC            (BOOT_PC),
        .MAX_OUTSTANDING    (MAX_OUTSTANDING)
    ) u_frontend (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (cu_flush),
        .stall_i        (cu_stall),
        .res_i          (be_res),
        .imem_req_rdy_i (imem_req_rdy_i),
        .imem_ans_i     (imem_ans_i),
        .imem_req_o     (imem_req_o),
        .issue_ready_i  (be_fe_ready),
        .fetch_valid_o  (fe_be_valid),
        .fetch_o        (fe_be_fetch)
    );

    backend u_backend (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (cu_flush),
        .stall_i        (cu_stall),
        .fetch_valid_i  (fe_be_valid),
        .fetch_i        (fe_be_fetch),
        .issue_ready_o  (be_fe_ready),
        .res_o          (be_res),
        .except_o       (be_except),
        .retire_o       (retire_o)
    );

endmodule

`default_nettype wire

/* rtl/main_cu.sv */
// An exception halts the core until reset, there are no trap vectors
`timescale 1ns/1ns
`default_nettype none

module main_cu (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  core_pkg::resolution_t   res_i,
    input  core_pkg::except_t       except_i,
    output logic                    flush_o,
    output logic                    stall_o,
    output logic                    halted_o,
    output core_pkg::except_t       except_o
);

    logic                       halted_q;
    logic [isa_pkg::XLEN-1:0]   except_pc_q;

    // Same-cycle flush on redirect or exception
    assign flush_o  = res_i.valid | except_i.valid;
    assign stall_o  = halted_q;
    assign halted_o = halted_q;

    always_comb begin
        except_o.valid = halted_q;
        except_o.pc    = except_pc_q;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            halted_q <= 1'b0;
        end else if (except_i.valid) begin
            halted_q <= 1'b1;
        end
    end

    // First exception wins
    always_ff @(posedge clk_i) begin
        if (except_i.valid && !halted_q) begin
            except_pc_q <= except_i.pc;
        end
    end

    a_quiet_halt: assert property (@(posedge clk_i) disable iff (reset_i)
        halted_q |-> !(res_i.valid || except_i.valid));

endmodule

`default_nettype wire

/* frontend/frontend.sv */
// Always predicts fall-through, redirects come from the backend only
// Memory must answer every accepted request once, in order
`timescale 1ns/1ns
`default_nettype none

module frontend #(
    parameter logic [isa_pkg::XLEN-1:0] BOOT_PC         = '0,
    parameter int unsigned              MAX_OUTSTANDING = 2
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    stall_i,
    input  core_pkg::resolution_t   res_i,
    input  logic                    imem_req_rdy_i,
    input  core_pkg::imem_ans_t     imem_ans_i,
    output core_pkg::imem_req_t     imem_req_o,
    input  logic                    issue_ready_i,
    output logic                    fetch_valid_o,
    output core_pkg::fetch_t        fetch_o
);

    localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

    // ------------------------------
    // State
    // ------------------------------
    logic [isa_pkg::XLEN-1:0]   pc_q;
    logic [isa_pkg::XLEN-1:0]   ans_pc_q;   // PC of the next kept answer
    logic [CNT_W-1:0]           inflight_q;
    logic [CNT_W-1:0]           stale_q;
    logic [CNT_W-1:0]           count_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [PTR_W-1:0]           wr_ptr_q;
    core_pkg::fetch_t           buf_q [MAX_OUTSTANDING];

    logic [CNT_W:0]             occupancy;
    logic                       req_valid;
    logic                       req_fire;
    logic                       ans_drop;
    logic                       push;
    logic                       pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // In flight plus buffered bounds new requests
    assign occupancy = (CNT_W+1)'(inflight_q) + (CNT_W+1)'(count_q);
    assign req_valid = ~reset_i & ~stall_i & ~flush_i
                     & (occupancy < (CNT_W+1)'(MAX_OUTSTANDING));
    assign req_fire  = req_valid & imem_req_rdy_i;

    always_comb begin
        imem_req_o.valid = req_valid;
        imem_req_o.addr  = pc_q;
    end

    assign ans_drop = imem_ans_i.valid & (stale_q != '0);
    assign push     = imem_ans_i.valid & ~flush_i & (stale_q == '0);

    assign fetch_valid_o = (count_q != '0);
    assign fetch_o       = buf_q[rd_ptr_q];
    assign pop           = fetch_valid_o & issue_ready_i;

    // ------------------------------
    // Counters and pointers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q       <= BOOT_PC;
            ans_pc_q   <= BOOT_PC;
            inflight_q <= '0;
            stale_q    <= '0;
            count_q    <= '0;
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
        end else begin
            inflight_q <= inflight_q + CNT_W'(req_fire) - CNT_W'(imem_ans_i.valid);
            if (flush_i) begin
                // Everything still unanswered belongs to the old path
                stale_q  <= inflight_q - CNT_W'(imem_ans_i.valid);
                count_q  <= '0;
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                if (res_i.valid) begin
                    pc_q     <= res_i.target;
                    ans_pc_q <= res_i.target;
                end
            end else begin
                if (ans_drop) begin
                    stale_q <= stale_q - 1'b1;
                end
                if (req_fire) begin
                    pc_q <= pc_q + 32'd4;
                end
                if (push) begin
                    wr_ptr_q <= ptr_inc(wr_ptr_q);
                    ans_pc_q <= ans_pc_q + 32'd4;
                end
                if (pop) begin
                    rd_ptr_q <= ptr_inc(rd_ptr_q);
                end
                count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    // Instruction buffer
    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= '{pc: ans_pc_q, instr: imem_ans_i.data};
        end
    end

    // Request limit must keep room for every answer
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push |-> (count_q < CNT_W'(MAX_OUTSTANDING)) || pop);

    a_ans_expected: assert property (@(posedge clk_i) disable iff (reset_i)
        imem_ans_i.valid |-> inflight_q != '0);

endmodule

`default_nettype wire

/* backend/backend.sv */
// One instruction per cycle, no hazards since execute completes in one cycle
// Illegal encodings write nothing and raise except_o
`timescale 1ns/1ns
`default_nettype none

module backend (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    stall_i,
    input  logic                    fetch_valid_i,
    input  core_pkg::fetch_t        fetch_i,
    output logic                    issue_ready_o,
    output core_pkg::resolution_t   res_o,
    output core_pkg::except_t       except_o,
    output core_pkg::retire_t       retire_o
);

    logic [isa_pkg::OPC_W-1:0]      opcode;
    logic [isa_pkg::FUNCT3_W-1:0]   funct3;
    logic [isa_pkg::FUNCT7_W-1:0]   funct7;
    logic [isa_pkg::REG_ADDR_W-1:0] rd_addr;
    isa_pkg::op_e                   op;

    logic [isa_pkg::XLEN-1:0]       imm_i;
    logic [isa_pkg::XLEN-1:0]       imm_u;
    logic [isa_pkg::XLEN-1:0]       imm_b;
    logic [isa_pkg::XLEN-1:0]       imm_j;
    logic [isa_pkg::XLEN-1:0]       rs1_data;
    logic [isa_pkg::XLEN-1:0]       rs2_data;
    logic [isa_pkg::XLEN-1:0]       result;
    logic [isa_pkg::XLEN-1:0]       target;
    logic                           writes_rd;
    logic                           taken;
    logic                           accept;
    logic                           illegal;

    logic                           retire_valid_q;
    logic [isa_pkg::XLEN-1:0]       retire_pc_q;
    logic [isa_pkg::REG_ADDR_W-1:0] retire_rd_q;
    logic [isa_pkg::XLEN-1:0]       retire_value_q;

    // ------------------------------
    // Decode
    // ------------------------------
    assign opcode  = fetch_i.instr[6:0];
    assign funct3  = fetch_i.instr[14:12];
    assign funct7  = fetch_i.instr[31:25];
    assign rd_addr = fetch_i.instr[11:7];

    assign imm_i = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
    assign imm_u = {fetch_i.instr[31:12], 12'b0};
    assign imm_b = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
                    fetch_i.instr[11:8], 1'b0};
    assign imm_j = {{12{fetch_i.instr[31]}}, fetch_i.instr[19:12], fetch_i.instr[20],
                    fetch_i.instr[30:21], 1'b0};

    always_comb begin
        op = isa_pkg::OP_ILLEGAL;
        case (opcode)
            isa_pkg::OPC_LUI: op = isa_pkg::OP_LUI;
            isa_pkg::OPC_OPIMM: begin
                if (funct3 == isa_pkg::F3_ADD) op = isa_pkg::OP_ADDI;
            end
            isa_pkg::OPC_OP: begin
                if (funct3 == isa_pkg::F3_ADD && funct7 == isa_pkg::F7_ADD) begin
                    op = isa_pkg::OP_ADD;
                end else if (funct3 == isa_pkg::F3_ADD && funct7 == isa_pkg::F7_SUB) begin
                    op = isa_pkg::OP_SUB;
                end
            end
            isa_pkg::OPC_BRANCH: begin
                if (funct3 == isa_pkg::F3_BEQ) begin
                    op = isa_pkg::OP_BEQ;
                end else if (funct3 == isa_pkg::F3_BNE) begin
                    op = isa_pkg::OP_BNE;
                end
            end
            isa_pkg::OPC_JAL: op = isa_pkg::OP_JAL;
            default: op = isa_pkg::OP_ILLEGAL;
        endcase
    end

    reg_file u_reg_file (
        .clk_i          (clk_i),
        .rs1_addr_i     (fetch_i.instr[19:15]),
        .rs2_addr_i     (fetch_i.instr[24:20]),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .we_i           (accept & writes_rd),
        .rd_addr_i      (rd_addr),
        .rd_data_i      (result)
    );

    // ------------------------------
    // Execute and branch resolution
    // ------------------------------
    always_comb begin
        result    = '0;
        writes_rd = 1'b0;
        taken     = 1'b0;
        target    = fetch_i.pc + imm_b;
        case (op)
            isa_pkg::OP_LUI: begin
                result    = imm_u;
                writes_rd = 1'b1;
            end
            isa_pkg::OP_ADDI: begin
                result    = rs1_data + imm_i;
                writes_rd = 1'b1;
            end
            isa_pkg::OP_ADD: begin
                result    = rs1_data + rs2_data;
                writes_rd = 1'b1;
            end
            isa_pkg::OP_SUB: begin
                result    = rs1_data - rs2_data;
                writes_rd = 1'b1;
            end
            isa_pkg::OP_BEQ: taken = (rs1_data == rs2_data);
            isa_pkg::OP_BNE: taken = (rs1_data != rs2_data);
            isa_pkg::OP_JAL: begin
                // Link register gets the return address
                result    = fetch_i.pc + 32'd4;
                writes_rd = 1'b1;
                taken     = 1'b1;
                target    = fetch_i.pc + imm_j;
            end
            default: ;
        endcase
    end

    assign issue_ready_o = ~stall_i;
    assign accept        = fetch_valid_i & issue_ready_o;
    assign illegal       = (op == isa_pkg::OP_ILLEGAL);

    always_comb begin
        res_o.valid     = accept & taken;
        res_o.target    = target;
        except_o.valid  = accept & illegal;
        except_o.pc     = fetch_i.pc;
    end

    // ------------------------------
    // Retire report
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= accept & ~illegal;
        end
    end

    // Branches report rd zero, x0 writes report value zero
    always_ff @(posedge clk_i) begin
        if (accept) begin
            retire_pc_q    <= fetch_i.pc;
            retire_rd_q    <= writes_rd ? rd_addr : '0;
            retire_value_q <= (writes_rd && rd_addr != '0) ? result : '0;
        end
    end

    always_comb begin
        retire_o.valid = retire_valid_q;
        retire_o.pc    = retire_pc_q;
        retire_o.rd    = retire_rd_q;
        retire_o.value = retire_value_q;
    end

    // Halt must leave nothing to issue
    a_stall_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_i |-> !fetch_valid_i);

    // A flush only comes back from our own redirect or exception
    a_flush_source: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |-> accept && (res_o.valid || except_o.valid));

endmodule

`default_nettype wire

/* backend/reg_file.sv */
// Reads are asynchronous and do not bypass a same-cycle write
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                            clk_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [isa_pkg::XLEN-1:0]        rs1_data_o,
    output logic [isa_pkg::XLEN-1:0]        rs2_data_o,
    input  logic                            we_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [isa_pkg::XLEN-1:0]        rd_data_i
);

    logic [isa_pkg::XLEN-1:0] regs_q [2**isa_pkg::REG_ADDR_W];

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (we_i && rd_addr_i != '0) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* common/core_pkg.sv */
// Structs passed between the core blocks and to the instruction memory
// Every record with a valid bit is meaningful only while valid is high
`default_nettype none

package core_pkg;

    // Fetch request to instruction memory
    typedef struct packed {
        logic                       valid;
        logic [isa_pkg::XLEN-1:0]   addr;
    } imem_req_t;

    // Memory answer, in request order
    typedef struct packed {
        logic                       valid;
        logic [isa_pkg::ILEN-1:0]   data;
    } imem_ans_t;

    // Buffered instruction with its PC
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]   pc;
        logic [isa_pkg::ILEN-1:0]   instr;
    } fetch_t;

    // Redirect from a taken branch or JAL
    typedef struct packed {
        logic                       valid;
        logic [isa_pkg::XLEN-1:0]   target;
    } resolution_t;

    // One completed instruction
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::XLEN-1:0]       pc;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       value;
    } retire_t;

    // Illegal instruction report
    typedef struct packed {
        logic                       valid;
        logic [isa_pkg::XLEN-1:0]   pc;
    } except_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
// RV32I subset only: LUI, ADDI, ADD, SUB, BEQ, BNE and JAL
// Base 32-bit encodings, no compressed instructions
`default_nettype none

package isa_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned ILEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned OPC_W      = 7;
    localparam int unsigned FUNCT3_W   = 3;
    localparam int unsigned FUNCT7_W   = 7;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;

    // ------------------------------
    // Function codes
    // ------------------------------
    // ADD, SUB and ADDI share funct3 000
    localparam logic [FUNCT3_W-1:0] F3_ADD = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BEQ = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE = 3'b001;

    localparam logic [FUNCT7_W-1:0] F7_ADD = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_SUB = 7'b0100000;

    // Decoded operation
    typedef enum logic [2:0] {
        OP_LUI,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_ILLEGAL
    } op_e;

endpackage

`default_nettype wire
